//--- compile.f
+incdir+include
rtl/ctrl_pkg.sv
rtl/instr_sequencer.sv
rtl/alu_op_exec.sv
rtl/mem_access_exec.sv
rtl/flow_change_exec.sv
rtl/multicycle_controller.sv
tb/clock_gen.sv
tb/controller_tb.sv

//--- include/ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

////////////////////
// Field widths
////////////////////

`define CTRL_OPCODE_W   7
`define CTRL_FUNC3_W    3
`define CTRL_SEL_W      2       // PC source and write-back select

////////////////////
// RV32I opcodes
////////////////////

`define CTRL_OP_RTYPE   7'b0110011
`define CTRL_OP_ITYPE   7'b0010011
`define CTRL_OP_LOAD    7'b0000011
`define CTRL_OP_STORE   7'b0100011
`define CTRL_OP_BRANCH  7'b1100011
`define CTRL_OP_JAL     7'b1101111
`define CTRL_OP_JALR    7'b1100111

////////////////////
// func3 size codes
////////////////////

// Signed sizes are shared by loads and stores
`define CTRL_F3_BYTE    3'b000
`define CTRL_F3_HALF    3'b001
`define CTRL_F3_WORD    3'b010

// Zero-extended sizes exist for loads only
`define CTRL_F3_BYTE_U  3'b100
`define CTRL_F3_HALF_U  3'b101

`endif

//--- rtl/alu_op_exec.sv
`timescale 1ns/1ns
`default_nettype none

module alu_op_exec
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     alu_start,
    input  var ctrl_pkg::op_class_e op_class,
    output logic                    alu_src,
    output logic                    reg_write,
    output logic                    alu_done
);

    logic write_q;     // Single write cycle after the start strobe

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            write_q <= 1'b0;
        else
            write_q <= alu_start;
    end

    // Immediate ops take operand B from the immediate
    assign alu_src   = write_q && (op_class == ctrl_pkg::CLASS_I);
    assign reg_write = write_q;
    assign alu_done  = write_q;     // Finished in the write cycle

endmodule

`default_nettype wire

//--- rtl/ctrl_pkg.sv
`default_nettype none

`include "ctrl_params.svh"

package ctrl_pkg;

    // Instruction class seen by the executors
    typedef enum logic [2:0]
    {
        CLASS_NONE   = 3'd0,    // Unknown opcode
        CLASS_R      = 3'd1,
        CLASS_I      = 3'd2,
        CLASS_LOAD   = 3'd3,
        CLASS_STORE  = 3'd4,
        CLASS_BRANCH = 3'd5,
        CLASS_JUMP   = 3'd6     // JAL and JALR
    } op_class_e;

    // Next PC source
    typedef enum logic [`CTRL_SEL_W-1:0]
    {
        PC_SEQ    = 2'b00,      // PC + 4
        PC_BRANCH = 2'b01,
        PC_JUMP   = 2'b10
    } pc_sel_e;

    // Register file write-back source
    typedef enum logic [`CTRL_SEL_W-1:0]
    {
        WB_ALU  = 2'b00,
        WB_MEM  = 2'b01,
        WB_LINK = 2'b10         // Return address
    } wb_sel_e;

endpackage

`default_nettype wire

//--- rtl/flow_change_exec.sv
`timescale 1ns/1ns
`default_nettype none

module flow_change_exec
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     flow_start,
    input  var ctrl_pkg::op_class_e op_class,
    input  wire                     comparator,
    output logic                    pc_en,
    output ctrl_pkg::pc_sel_e       pc_select,
    output logic                    reg_write,
    output ctrl_pkg::wb_sel_e       mem_to_reg,
    output logic                    flow_done
);

    logic active_q;
    logic taken_q;      // Branch condition at start
    logic is_jump;
    logic is_taken;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            active_q <= 1'b0;
        else
            active_q <= flow_start;
    end

    always_ff @(posedge clk)
    begin
        if (flow_start)
            taken_q <= comparator;
    end

    assign is_jump  = active_q && (op_class == ctrl_pkg::CLASS_JUMP);
    assign is_taken = active_q && (op_class == ctrl_pkg::CLASS_BRANCH) && taken_q;

    ////////////////////
    // PC redirect and link write
    ////////////////////

    always_comb
    begin
        pc_select  = ctrl_pkg::PC_SEQ;
        mem_to_reg = ctrl_pkg::WB_ALU;
        if (is_jump)
        begin
            pc_select  = ctrl_pkg::PC_JUMP;
            mem_to_reg = ctrl_pkg::WB_LINK;    // rd gets PC + 4
        end
        else if (is_taken)
            pc_select = ctrl_pkg::PC_BRANCH;
    end

    assign pc_en     = is_jump || is_taken;
    assign reg_write = is_jump;         // Branches never write rd
    assign flow_done = active_q;

    // Launched only for a branch or a jump
    a_flow_class: assert property (@(posedge clk) disable iff (reset)
        active_q |-> (op_class inside {ctrl_pkg::CLASS_BRANCH, ctrl_pkg::CLASS_JUMP}));

endmodule

`default_nettype wire

//--- rtl/instr_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_params.svh"

module instr_sequencer
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       go,
    input  wire [`CTRL_OPCODE_W-1:0]  opcode,
    input  wire                       alu_done,
    input  wire                       mem_done,
    input  wire                       flow_done,
    output logic                      ir_en,
    output logic                      seq_pc_en,
    output ctrl_pkg::op_class_e       op_class,
    output logic                      alu_start,
    output logic                      mem_start,
    output logic                      flow_start,
    output logic                      instr_done
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_FETCH,
        S_PCSTEP,
        S_DECODE,
        S_EXEC,
        S_DONE
    } seq_state_e;

    seq_state_e          state_q;
    seq_state_e          state_d;
    ctrl_pkg::op_class_e decoded_class;
    logic                any_done;

    ////////////////////
    // Opcode classification
    ////////////////////

    always_comb
    begin
        case (opcode)
            `CTRL_OP_RTYPE:  decoded_class = ctrl_pkg::CLASS_R;
            `CTRL_OP_ITYPE:  decoded_class = ctrl_pkg::CLASS_I;
            `CTRL_OP_LOAD:   decoded_class = ctrl_pkg::CLASS_LOAD;
            `CTRL_OP_STORE:  decoded_class = ctrl_pkg::CLASS_STORE;
            `CTRL_OP_BRANCH: decoded_class = ctrl_pkg::CLASS_BRANCH;
            `CTRL_OP_JAL,
            `CTRL_OP_JALR:   decoded_class = ctrl_pkg::CLASS_JUMP;   // Same sequence for both
            default:         decoded_class = ctrl_pkg::CLASS_NONE;
        endcase
    end

    assign any_done = alu_done | mem_done | flow_done;

    ////////////////////
    // State machine
    ////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (go) state_d = S_FETCH;
            S_FETCH:  state_d = S_PCSTEP;
            S_PCSTEP: state_d = S_DECODE;
            S_DECODE: state_d = (decoded_class == ctrl_pkg::CLASS_NONE) ? S_DONE : S_EXEC;
            S_EXEC:   if (any_done) state_d = S_DONE;   // Wait on the executor
            S_DONE:   state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_q  <= S_IDLE;
            op_class <= ctrl_pkg::CLASS_NONE;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == S_DECODE)
                op_class <= decoded_class;  // Held until the next decode
        end
    end

    // Strobes and levels decoded from the state
    assign ir_en      = (state_q == S_FETCH);
    assign seq_pc_en  = (state_q == S_PCSTEP);
    assign instr_done = (state_q == S_DONE);

    assign alu_start  = (state_q == S_DECODE) &&
                        (decoded_class inside {ctrl_pkg::CLASS_R, ctrl_pkg::CLASS_I});
    assign mem_start  = (state_q == S_DECODE) &&
                        (decoded_class inside {ctrl_pkg::CLASS_LOAD, ctrl_pkg::CLASS_STORE});
    assign flow_start = (state_q == S_DECODE) &&
                        (decoded_class inside {ctrl_pkg::CLASS_BRANCH, ctrl_pkg::CLASS_JUMP});

    // Only one executor may answer at a time
    a_one_done: assert property (@(posedge clk) disable iff (reset)
        $onehot0({alu_done, mem_done, flow_done}));

    // An executor must not finish outside the execute phase
    a_done_in_exec: assert property (@(posedge clk) disable iff (reset)
        any_done |-> (state_q == S_EXEC));

endmodule

`default_nettype wire

//--- rtl/mem_access_exec.sv
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_params.svh"

module mem_access_exec
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       mem_start,
    input  var ctrl_pkg::op_class_e   op_class,
    input  wire [`CTRL_FUNC3_W-1:0]   func3,
    output logic                      alu_src,
    output logic                      reg_write,
    output ctrl_pkg::wb_sel_e         mem_to_reg,
    output logic                      is_byte,
    output logic                      is_half,
    output logic                      is_word,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      mem_done
);

    typedef enum logic [1:0]
    {
        M_IDLE,
        M_ACCESS,
        M_WRITE
    } mem_state_e;

    mem_state_e               state_q;
    logic [`CTRL_FUNC3_W-1:0] func3_q;
    logic [2:0]               size;        // {word, half, byte}
    logic                     is_load;
    logic                     is_store;
    logic                     access_ok;
    logic                     in_access;
    logic                     in_write;

    always_ff @(posedge clk)
    begin
        if (mem_start)
            func3_q <= func3;
    end

    assign is_load   = (op_class == ctrl_pkg::CLASS_LOAD);
    assign is_store  = (op_class == ctrl_pkg::CLASS_STORE);

    ////////////////////
    // Size decode
    ////////////////////

    always_comb
    begin
        size = 3'b000;
        case (func3_q)
            `CTRL_F3_BYTE:   size = 3'b001;
            `CTRL_F3_HALF:   size = 3'b010;
            `CTRL_F3_WORD:   size = 3'b100;
            `CTRL_F3_BYTE_U: if (is_load) size = 3'b001;   // No unsigned stores
            `CTRL_F3_HALF_U: if (is_load) size = 3'b010;
            default:         size = 3'b000;
        endcase
    end

    assign access_ok = |size;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state_q <= M_IDLE;
        else
            case (state_q)
                M_IDLE:   if (mem_start) state_q <= M_ACCESS;
                M_ACCESS: state_q <= (is_load && access_ok) ? M_WRITE : M_IDLE;
                default:  state_q <= M_IDLE;
            endcase
    end

    assign in_access = (state_q == M_ACCESS);
    assign in_write  = (state_q == M_WRITE);

    // Address comes from rs1 + immediate in both cycles
    assign alu_src    = (in_access && access_ok) || in_write;
    assign mem_read   = in_access && is_load && access_ok;
    assign mem_write  = in_access && is_store && access_ok;
    assign {is_word, is_half, is_byte} = in_access ? size : 3'b000;
    assign reg_write  = in_write;
    assign mem_to_reg = in_write ? ctrl_pkg::WB_MEM : ctrl_pkg::WB_ALU;
    assign mem_done   = in_write || (in_access && !(is_load && access_ok));

    // A new start must not arrive while an access is running
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        mem_start |-> (state_q == M_IDLE));

    // The latched class must stay a load or store while busy
    a_class_held: assert property (@(posedge clk) disable iff (reset)
        (in_access || in_write) |-> (is_load || is_store));

endmodule

`default_nettype wire

//--- rtl/multicycle_controller.sv
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_params.svh"

module multicycle_controller
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       go,
    input  wire [`CTRL_OPCODE_W-1:0]  opcode,
    input  wire [`CTRL_FUNC3_W-1:0]   func3,
    input  wire                       comparator,
    output logic                      ir_en,
    output logic                      pc_en,
    output ctrl_pkg::pc_sel_e         pc_select,
    output logic                      alu_src,
    output logic                      reg_write,
    output ctrl_pkg::wb_sel_e         mem_to_reg,
    output logic                      is_byte,
    output logic                      is_half,
    output logic                      is_word,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      instr_done
);

    ctrl_pkg::op_class_e op_class;
    ctrl_pkg::wb_sel_e   mem_wb_sel;
    ctrl_pkg::wb_sel_e   flow_wb_sel;
    logic                seq_pc_en;
    logic                flow_pc_en;
    logic                alu_start, mem_start, flow_start;
    logic                alu_done, mem_done, flow_done;
    logic                alu_alu_src, mem_alu_src;
    logic                alu_reg_write, mem_reg_write, flow_reg_write;

    instr_sequencer u_seq
    (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .opcode     (opcode),
        .alu_done   (alu_done),
        .mem_done   (mem_done),
        .flow_done  (flow_done),
        .ir_en      (ir_en),
        .seq_pc_en  (seq_pc_en),
        .op_class   (op_class),
        .alu_start  (alu_start),
        .mem_start  (mem_start),
        .flow_start (flow_start),
        .instr_done (instr_done)
    );

    alu_op_exec u_alu
    (
        .clk       (clk),
        .reset     (reset),
        .alu_start (alu_start),
        .op_class  (op_class),
        .alu_src   (alu_alu_src),
        .reg_write (alu_reg_write),
        .alu_done  (alu_done)
    );

    mem_access_exec u_mem
    (
        .clk        (clk),
        .reset      (reset),
        .mem_start  (mem_start),
        .op_class   (op_class),
        .func3      (func3),
        .alu_src    (mem_alu_src),
        .reg_write  (mem_reg_write),
        .mem_to_reg (mem_wb_sel),
        .is_byte    (is_byte),
        .is_half    (is_half),
        .is_word    (is_word),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_done   (mem_done)
    );

    flow_change_exec u_flow
    (
        .clk        (clk),
        .reset      (reset),
        .flow_start (flow_start),
        .op_class   (op_class),
        .comparator (comparator),
        .pc_en      (flow_pc_en),
        .pc_select  (pc_select),   // Sole source as the PC step uses PC_SEQ
        .reg_write  (flow_reg_write),
        .mem_to_reg (flow_wb_sel),
        .flow_done  (flow_done)
    );

    ////////////////////
    // Output merge
    ////////////////////

    // Idle blocks drive zero so a plain OR selects the active one
    assign pc_en      = seq_pc_en | flow_pc_en;
    assign alu_src    = alu_alu_src | mem_alu_src;
    assign reg_write  = alu_reg_write | mem_reg_write | flow_reg_write;
    assign mem_to_reg = ctrl_pkg::wb_sel_e'(mem_wb_sel | flow_wb_sel);

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen
#(
    parameter int PERIOD = 20   // ns
)
(
    output logic clk
);

    initial
        clk = 1'b0;

    always
        #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- tb/controller_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_params.svh"

module controller_tb;

    localparam int NUM_ROWS   = 16;
    localparam int ROW_CYCLES = 20;     // Bound for one instruction

    logic                      clk, reset, go, comparator;
    logic [`CTRL_OPCODE_W-1:0] opcode;
    logic [`CTRL_FUNC3_W-1:0]  func3;
    logic                      ir_en, pc_en, alu_src, reg_write, instr_done;
    logic                      is_byte, is_half, is_word, mem_read, mem_write;
    ctrl_pkg::pc_sel_e         pc_select;
    ctrl_pkg::wb_sel_e         mem_to_reg;

    ////////////////////
    // Instruction table
    ////////////////////

    string                     row_name [NUM_ROWS];
    logic [`CTRL_OPCODE_W-1:0] row_op [NUM_ROWS];
    logic [`CTRL_FUNC3_W-1:0]  row_f3 [NUM_ROWS];
    logic                      row_cmp [NUM_ROWS];
    logic [35:0]               row_exp [NUM_ROWS];     // One hex digit per field
    int                        row_count = 0;

    clock_gen #(.PERIOD(20)) u_clk (.clk(clk));

    multicycle_controller UUT (.*);

    task automatic compare(input string what, input logic [35:0] expected, actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected %h, actual %h", what, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Every control output and strobe must be low
    task automatic check_idle(input string what);
        compare(what, 36'h0, {ir_en, pc_en, pc_select, alu_src, reg_write, mem_to_reg,
                              is_byte, is_half, is_word, mem_read, mem_write, instr_done});
    endtask

    task automatic add_row(input string name, input logic [`CTRL_OPCODE_W-1:0] op,
                           input logic [`CTRL_FUNC3_W-1:0] f3, input logic cmp,
                           input logic [35:0] expected);
        row_name[row_count] = name;
        row_op[row_count]   = op;
        row_f3[row_count]   = f3;
        row_cmp[row_count]  = cmp;
        row_exp[row_count]  = expected;
        row_count++;
    endtask

    // Runs one instruction and totals the outputs up to instr_done
    task automatic run_row(input int idx);
        logic [3:0] n_ir = 0, n_pc = 0, n_rw = 0, n_rd = 0, n_wr = 0;
        logic [3:0] size = 0, src = 0, exec_sel = 0, wb = 0;
        logic [1:0] step_sel = 0;
        logic       finished = 0;
        opcode     = row_op[idx];
        func3      = row_f3[idx];
        comparator = row_cmp[idx];
        go         = 1'b1;
        @(negedge clk);
        go         = 1'b0;      // One cycle of go is enough
        while (!finished)
        begin
            n_ir = n_ir + ir_en;
            n_rw = n_rw + reg_write;
            n_rd = n_rd + mem_read;
            n_wr = n_wr + mem_write;
            if (pc_en && n_pc == 0)
                step_sel = pc_select;                   // Sequential PC step
            else if (pc_en)
                exec_sel = exec_sel | pc_select;        // Redirect from the executor
            n_pc = n_pc + pc_en;
            if (reg_write)
                wb = wb | mem_to_reg;
            if (reg_write || mem_read || mem_write)
                src = src | alu_src;
            size = size | {is_word, is_half, is_byte};
            finished = instr_done;
            @(negedge clk);
        end
        compare({row_name[idx], " step select"}, ctrl_pkg::PC_SEQ, step_sel);
        compare(row_name[idx], row_exp[idx],
                {n_ir, n_pc, n_rw, n_rd, n_wr, size, src, exec_sel, wb});
    endtask

    initial
    begin
        reset      = 1'b1;
        go         = 1'b0;
        opcode     = '0;
        func3      = '0;
        comparator = 1'b0;

        // Digits from the left are ir_en pc_en reg_write mem_read mem_write totals,
        // then size {word half byte}, alu_src, execute pc_select and mem_to_reg
        add_row("r_type",  `CTRL_OP_RTYPE,  3'b000, 1'b0, 36'h1_1_1_0_0_0_0_0_0);
        add_row("i_type",  `CTRL_OP_ITYPE,  3'b000, 1'b0, 36'h1_1_1_0_0_0_1_0_0);
        add_row("lb",      `CTRL_OP_LOAD,   3'b000, 1'b0, 36'h1_1_1_1_0_1_1_0_1);
        add_row("lbu",     `CTRL_OP_LOAD,   3'b100, 1'b0, 36'h1_1_1_1_0_1_1_0_1);
        add_row("lh",      `CTRL_OP_LOAD,   3'b001, 1'b0, 36'h1_1_1_1_0_2_1_0_1);
        add_row("lhu",     `CTRL_OP_LOAD,   3'b101, 1'b0, 36'h1_1_1_1_0_2_1_0_1);
        add_row("lw",      `CTRL_OP_LOAD,   3'b010, 1'b0, 36'h1_1_1_1_0_4_1_0_1);
        add_row("sb",      `CTRL_OP_STORE,  3'b000, 1'b0, 36'h1_1_0_0_1_1_1_0_0);
        add_row("sh",      `CTRL_OP_STORE,  3'b001, 1'b0, 36'h1_1_0_0_1_2_1_0_0);
        add_row("sw",      `CTRL_OP_STORE,  3'b010, 1'b0, 36'h1_1_0_0_1_4_1_0_0);
        add_row("sd",      `CTRL_OP_STORE,  3'b011, 1'b0, 36'h1_1_0_0_0_0_0_0_0);
        add_row("beq_t",   `CTRL_OP_BRANCH, 3'b000, 1'b1, 36'h1_2_0_0_0_0_0_1_0);
        add_row("beq_nt",  `CTRL_OP_BRANCH, 3'b000, 1'b0, 36'h1_1_0_0_0_0_0_0_0);
        add_row("jal",     `CTRL_OP_JAL,    3'b000, 1'b0, 36'h1_2_1_0_0_0_0_2_2);
        add_row("jalr",    `CTRL_OP_JALR,   3'b000, 1'b0, 36'h1_2_1_0_0_0_0_2_2);
        add_row("unknown", 7'b1111111,      3'b000, 1'b0, 36'h1_1_0_0_0_0_0_0_0);

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Nothing moves while go stays low
        repeat (5)
        begin
            check_idle("after reset");
            @(negedge clk);
        end

        for (int i = 0; i < row_count; i++)
        begin
            run_row(i);
            check_idle({row_name[i], " back in idle"});   // Also catches a second instr_done
        end

        $display("All checks passed");
        $finish;
    end

    // Watchdog sized from the table length plus the reset phase
    initial
    begin
        repeat ((NUM_ROWS + 1) * ROW_CYCLES) @(posedge clk);
        $display("The controller never finished its instructions before the time limit");
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
